//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run lsu_tb and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f tb.f --top-module lsu_tb \
		-Mdir obj_dir -o lsu_tb
	./obj_dir/lsu_tb | tee $(LOG)
	@grep -q "All tests passed!" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- include/lsu_consts.svh
`ifndef LSU_CONSTS_SVH
`define LSU_CONSTS_SVH

// Data and address width.
`define LSU_DATA_W 32

// Size of the SRAM in data words.
`define LSU_MEM_WORDS 256

// Cycles from address acceptance to the slave's response valid.
`define LSU_MEM_LATENCY 3

// Fixed AXI fields for single-beat transfers.
`define LSU_AXI_ID 4'h0
`define LSU_AXI_LEN 8'h00
`define LSU_AXI_BURST_INCR 2'b01

`endif

//--- tb.f
+incdir+include
verilog/lsu_pkg.sv
verilog/lsu_data_align.sv
verilog/lsu.sv
verilog/axi_sram_slave.sv
verilog/lsu_subsystem.sv
tb/lsu_assert.sv
tb/lsu_tb.sv

//--- tb/lsu_assert.sv
`timescale 1ns/1ps

module lsu_assert (
  input logic                clock,
  input logic                reset,
  input logic                in_exec,
  input logic                lsu2exu_ready,
  input logic                lsu2exu_valid,
  input lsu_pkg::axi_w_m2s_t w_m2s,
  input lsu_pkg::axi_w_s2m_t w_s2m,
  input lsu_pkg::axi_r_m2s_t r_m2s,
  input lsu_pkg::axi_r_s2m_t r_s2m
);

  // A store taken right after a load completes pulses again at once.
  valid_one_cycle: assert property (@(posedge clock) disable iff (reset)
    lsu2exu_valid |=> !lsu2exu_valid || (!lsu2exu_ready && $past(lsu2exu_ready)))
    else $error("lsu2exu_valid high for more than one cycle");

  arvalid_hold: assert property (@(posedge clock) disable iff (reset)
    r_m2s.arvalid && !r_s2m.arready |=> r_m2s.arvalid)
    else $error("arvalid dropped before arready");

  awvalid_hold: assert property (@(posedge clock) disable iff (reset)
    w_m2s.awvalid && !w_s2m.awready |=> w_m2s.awvalid)
    else $error("awvalid dropped before awready");

  aw_w_together: assert property (@(posedge clock) disable iff (reset)
    $rose(w_m2s.awvalid) == $rose(w_m2s.wvalid))
    else $error("awvalid and wvalid did not rise together");

  // No new request while a transaction is open.
  ready_low_in_exec: assert property (@(posedge clock) disable iff (reset)
    in_exec |-> !lsu2exu_ready)
    else $error("lsu2exu_ready high in EXEC");

endmodule

bind lsu lsu_assert lsu_assert_inst (
  .clock         (clock),
  .reset         (reset),
  .in_exec       (state == EXEC),
  .lsu2exu_ready (lsu2exu_ready),
  .lsu2exu_valid (lsu2exu_valid),
  .w_m2s         (lsu_w_m2s),
  .w_s2m         (lsu_w_s2m),
  .r_m2s         (lsu_r_m2s),
  .r_s2m         (lsu_r_s2m)
);

//--- tb/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu_tb;

  localparam int CLK_PERIOD = 100;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_OPS = 20;

  localparam lsu_pkg::access_size_t SIZE_B = 2'd0;
  localparam lsu_pkg::access_size_t SIZE_H = 2'd1;
  localparam lsu_pkg::access_size_t SIZE_W = 2'd2;

  typedef struct packed {
    logic                  write;
    lsu_pkg::addr_t        addr;
    lsu_pkg::access_size_t size;
    logic                  sext;
    lsu_pkg::data_t        wdata;
    lsu_pkg::data_t        rdata_exp;
  } op_t;

  logic                  clock;
  logic                  reset;
  logic                  exu2lsu_valid;
  logic                  lsu2exu_ready;
  lsu_pkg::addr_t        lsu_addr;
  lsu_pkg::access_size_t lsu_size;
  logic                  lsu_sext;
  logic                  lsu_write;
  lsu_pkg::data_t        lsu_wdata;
  logic                  lsu2exu_valid;
  lsu_pkg::data_t        lsu_rdata;

  op_t            ops [NUM_OPS];
  int             errors;
  int             checks;
  lsu_pkg::data_t last_load;

  lsu_subsystem lsu_subsystem_inst (
    .clock         (clock),
    .reset         (reset),
    .exu2lsu_valid (exu2lsu_valid),
    .lsu2exu_ready (lsu2exu_ready),
    .lsu_addr      (lsu_addr),
    .lsu_size      (lsu_size),
    .lsu_sext      (lsu_sext),
    .lsu_write     (lsu_write),
    .lsu_wdata     (lsu_wdata),
    .lsu2exu_valid (lsu2exu_valid),
    .lsu_rdata     (lsu_rdata)
  );

  always #(CLK_PERIOD / 2) clock = ~clock;

  function automatic op_t store_op(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                                   input lsu_pkg::data_t data);
    op_t op;
    op = '{1'b1, addr, size, 1'b0, data, 32'h0};
    return op;
  endfunction

  function automatic op_t load_op(input lsu_pkg::addr_t addr, input lsu_pkg::access_size_t size,
                                  input logic sext, input lsu_pkg::data_t exp);
    op_t op;
    op = '{1'b0, addr, size, sext, 32'h0, exp};
    return op;
  endfunction

  // Expected values follow the byte lanes of each store. A set sext means zero extension.
  task automatic fill_table();
    ops[0]  = load_op(32'h40, SIZE_W, 1'b0, 32'h0000_0000);
    ops[1]  = load_op(32'h83, SIZE_B, 1'b0, 32'h0000_0000);
    ops[2]  = store_op(32'h40, SIZE_W, 32'h8765_4321);
    ops[3]  = load_op(32'h40, SIZE_W, 1'b0, 32'h8765_4321);
    ops[4]  = load_op(32'h43, SIZE_B, 1'b0, 32'hFFFF_FF87);
    ops[5]  = load_op(32'h42, SIZE_B, 1'b1, 32'h0000_0065);
    ops[6]  = store_op(32'h44, SIZE_W, 32'h1122_3344);
    ops[7]  = store_op(32'h45, SIZE_B, 32'h1234_56AB);
    ops[8]  = store_op(32'h46, SIZE_H, 32'h5555_F00D);
    ops[9]  = load_op(32'h44, SIZE_W, 1'b0, 32'hF00D_AB44);
    ops[10] = load_op(32'h44, SIZE_B, 1'b0, 32'h0000_0044);
    ops[11] = load_op(32'h45, SIZE_B, 1'b0, 32'hFFFF_FFAB);
    ops[12] = load_op(32'h45, SIZE_B, 1'b1, 32'h0000_00AB);
    ops[13] = load_op(32'h47, SIZE_B, 1'b0, 32'hFFFF_FFF0);
    ops[14] = load_op(32'h46, SIZE_H, 1'b0, 32'hFFFF_F00D);
    ops[15] = load_op(32'h46, SIZE_H, 1'b1, 32'h0000_F00D);
    ops[16] = store_op(32'h40, SIZE_H, 32'hDEAD_BEEF);
    ops[17] = load_op(32'h40, SIZE_W, 1'b0, 32'h8765_BEEF);
    ops[18] = load_op(32'h40, SIZE_H, 1'b0, 32'hFFFF_BEEF);
    ops[19] = load_op(32'h42, SIZE_H, 1'b0, 32'hFFFF_8765);
  endtask

  task automatic check_true(input logic cond, input string what);
    checks++;
    assert (cond) else begin
      errors++;
      $display("Error at %0t: %s", $time, what);
    end
  endtask

  task automatic compare_word(input lsu_pkg::data_t got, input lsu_pkg::data_t exp,
                              input string what);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("MISMATCH at %0t: %s got 0x%08h expected 0x%08h", $time, what, got, exp);
    end
  endtask

  // Called 1 ns after a rising edge.
  task automatic present(input int idx);
    exu2lsu_valid = 1'b1;
    lsu_write     = ops[idx].write;
    lsu_addr      = ops[idx].addr;
    lsu_size      = ops[idx].size;
    lsu_sext      = ops[idx].sext;
    lsu_wdata     = ops[idx].wdata;
  endtask

  // Returns 1 ns after the edge that accepts the pending request.
  task automatic wait_accept();
    while (!lsu2exu_ready) begin
      @(negedge clock);
      check_true(!lsu2exu_valid, "completion pulse while the next request was held off");
    end
    @(posedge clock);
    #1;
  endtask

  task automatic wait_done(input int idx);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clock);
      cycles++;
    end while (!lsu2exu_valid);
    if (ops[idx].write) begin
      check_true(cycles == 1, "store completion did not follow acceptance directly");
      check_true(!lsu2exu_ready, "ready returned together with the early store completion");
      compare_word(lsu_rdata, last_load, $sformatf("op %0d rdata kept over store", idx));
    end else begin
      check_true(lsu2exu_ready, "ready not raised with the load completion");
      compare_word(lsu_rdata, ops[idx].rdata_exp, $sformatf("op %0d load", idx));
      last_load = ops[idx].rdata_exp;
    end
  endtask

  initial begin
    #((NUM_OPS * (`LSU_MEM_LATENCY + 10) + RESET_CYCLES) * CLK_PERIOD);
    $display("Timeout: the run did not finish, %0d errors seen so far", errors);
    $display("Test failures found");
    $finish;
  end

  initial begin
    clock         = 1'b0;
    reset         = 1'b1;
    exu2lsu_valid = 1'b0;
    lsu_addr      = '0;
    lsu_size      = '0;
    lsu_sext      = 1'b0;
    lsu_write     = 1'b0;
    lsu_wdata     = '0;
    errors        = 0;
    checks        = 0;
    last_load     = '0;
    fill_table();

    repeat (RESET_CYCLES) @(posedge clock);
    #1;
    reset = 1'b0;
    @(negedge clock);
    check_true(lsu2exu_ready, "ready low after reset");
    check_true(!lsu2exu_valid, "completion pulse after reset");

    // The next request goes out as soon as one is taken, so valid stays high.
    @(posedge clock);
    #1;
    present(0);
    for (int i = 0; i < NUM_OPS; i++) begin
      wait_accept();
      if (i + 1 < NUM_OPS) begin
        present(i + 1);
      end else begin
        exu2lsu_valid = 1'b0;
      end
      wait_done(i);
    end

    repeat (4) @(posedge clock);
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

//--- verilog/axi_sram_slave.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module axi_sram_slave (
  input  logic                clock,
  input  logic                reset,
  input  lsu_pkg::axi_w_m2s_t w_m2s,
  output lsu_pkg::axi_w_s2m_t w_s2m,
  input  lsu_pkg::axi_r_m2s_t r_m2s,
  output lsu_pkg::axi_r_s2m_t r_s2m
);

  localparam int IDX_W = $clog2(`LSU_MEM_WORDS);
  localparam int CNT_W = $clog2(`LSU_MEM_LATENCY + 1);
  localparam int LANES = `LSU_DATA_W / 8;

  typedef enum logic [1:0] {
    IDLE,
    WAIT,
    RESP
  } state_e;

  state_e           state;
  logic [CNT_W-1:0] cnt;
  logic             is_write;
  lsu_pkg::data_t   rdata_q;
  lsu_pkg::data_t   mem [`LSU_MEM_WORDS];

  logic [IDX_W-1:0] w_idx;
  logic [IDX_W-1:0] r_idx;
  logic             idle;
  logic             wr_accept;
  logic             rd_accept;
  logic             resp_taken;

  assign idle  = (state == IDLE);
  assign w_idx = w_m2s.awaddr[IDX_W+1:2];
  assign r_idx = r_m2s.araddr[IDX_W+1:2];

  // Address and data arrive together; a write wins over a read.
  assign wr_accept = idle & w_m2s.awvalid & w_m2s.wvalid;
  assign rd_accept = idle & r_m2s.arvalid & ~wr_accept;

  assign resp_taken = is_write ? w_m2s.bready : r_m2s.rready;

  always_comb begin
    w_s2m.awready = idle;
    w_s2m.wready  = idle;
    w_s2m.bvalid  = (state == RESP) & is_write;
    r_s2m.arready = idle;
    r_s2m.rvalid  = (state == RESP) & ~is_write;
    r_s2m.rdata   = rdata_q;
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `LSU_MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else if (wr_accept) begin
      for (int b = 0; b < LANES; b++) begin
        if (w_m2s.wstrb[b]) begin
          mem[w_idx][8*b +: 8] <= w_m2s.wdata[8*b +: 8];
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rd_accept) begin
      rdata_q <= mem[r_idx];
    end
  end

  // Counter covers the latency minus the cycle spent entering RESP.
  always_ff @(posedge clock) begin
    if (reset) begin
      state    <= IDLE;
      cnt      <= '0;
      is_write <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (wr_accept | rd_accept) begin
            state    <= WAIT;
            cnt      <= CNT_W'(`LSU_MEM_LATENCY - 1);
            is_write <= wr_accept;
          end
        end
        WAIT: begin
          if (cnt == '0) begin
            state <= RESP;
          end else begin
            cnt <= cnt - 1'b1;
          end
        end
        RESP: begin
          if (resp_taken) state <= IDLE;
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- verilog/lsu.sv
`timescale 1ns/1ps
`include "lsu_consts.svh"

module lsu (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  exu2lsu_valid,
  output logic                  lsu2exu_ready,
  input  lsu_pkg::addr_t        lsu_addr,
  input  lsu_pkg::access_size_t lsu_size,
  input  logic                  lsu_sext,
  input  logic                  lsu_write,
  input  lsu_pkg::data_t        lsu_wdata,
  output logic                  lsu2exu_valid,
  output lsu_pkg::data_t        lsu_rdata,
  output lsu_pkg::axi_w_m2s_t   lsu_w_m2s,
  input  lsu_pkg::axi_w_s2m_t   lsu_w_s2m,
  output lsu_pkg::axi_r_m2s_t   lsu_r_m2s,
  input  lsu_pkg::axi_r_s2m_t   lsu_r_s2m
);

  typedef enum logic {
    IDLE,
    EXEC
  } state_e;

  state_e state;
  state_e state_next;
  logic   accept;

  logic ar_valid;
  logic aw_valid;
  logic w_valid;
  logic r_ready;
  logic b_ready;

  lsu_pkg::addr_t        addr_q;
  lsu_pkg::access_size_t size_q;
  logic                  sext_q;
  lsu_pkg::data_t        wdata_q;
  lsu_pkg::strb_t        wstrb_q;

  lsu_pkg::access_size_t align_size;
  logic [1:0]            align_offset;
  lsu_pkg::strb_t        wstrb_lane;
  lsu_pkg::data_t        wdata_lane;
  lsu_pkg::data_t        rdata_ext;

  assign accept = (state == IDLE) & exu2lsu_valid & lsu2exu_ready;

  // Stores align the incoming request, loads the held one.
  assign align_size   = (state == IDLE) ? lsu_size : size_q;
  assign align_offset = (state == IDLE) ? lsu_addr[1:0] : addr_q[1:0];

  lsu_data_align lsu_data_align_inst (
    .size       (align_size),
    .offset     (align_offset),
    .wdata      (lsu_wdata),
    .sext       (sext_q),
    .rdata_raw  (lsu_r_s2m.rdata),
    .wstrb      (wstrb_lane),
    .wdata_lane (wdata_lane),
    .rdata_ext  (rdata_ext)
  );

  always_ff @(posedge clock) begin
    if (reset) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE: if (accept) state_next = EXEC;
      EXEC: if (lsu_r_s2m.rvalid | lsu_w_s2m.bvalid) state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // Execute-side handshake. Stores complete early.
  always_ff @(posedge clock) begin
    if (reset) begin
      lsu2exu_valid <= 1'b0;
      lsu2exu_ready <= 1'b1;
      lsu_rdata     <= '0;
    end else begin
      lsu2exu_valid <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            lsu2exu_valid <= lsu_write;
            lsu2exu_ready <= 1'b0;
          end else begin
            lsu2exu_ready <= 1'b1;
          end
        end
        EXEC: begin
          if (lsu_r_s2m.rvalid) begin
            lsu2exu_valid <= 1'b1;
            lsu2exu_ready <= 1'b1;
            lsu_rdata     <= rdata_ext;
          end else if (lsu_w_s2m.bvalid) begin
            lsu2exu_ready <= 1'b1;
          end
        end
        default: lsu2exu_ready <= 1'b1;
      endcase
    end
  end

  // AXI valids and response readies.
  always_ff @(posedge clock) begin
    if (reset) begin
      ar_valid <= 1'b0;
      aw_valid <= 1'b0;
      w_valid  <= 1'b0;
      r_ready  <= 1'b0;
      b_ready  <= 1'b0;
    end else begin
      r_ready <= 1'b0;
      b_ready <= 1'b0;
      case (state)
        IDLE: begin
          if (accept) begin
            ar_valid <= ~lsu_write;
            aw_valid <= lsu_write;
            w_valid  <= lsu_write;
          end
        end
        EXEC: begin
          if (lsu_r_s2m.arready) ar_valid <= 1'b0;
          if (lsu_w_s2m.awready) aw_valid <= 1'b0;
          if (lsu_w_s2m.wready) w_valid <= 1'b0;
          r_ready <= lsu_r_s2m.rvalid;
          b_ready <= lsu_w_s2m.bvalid;
        end
        default: ;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (accept) begin
      addr_q <= lsu_addr;
      size_q <= lsu_size;
      if (lsu_write) begin
        wdata_q <= wdata_lane;
        wstrb_q <= wstrb_lane;
      end else begin
        sext_q <= lsu_sext;
      end
    end
  end

  always_comb begin
    lsu_w_m2s.awid    = `LSU_AXI_ID;
    lsu_w_m2s.awaddr  = addr_q;
    lsu_w_m2s.awlen   = `LSU_AXI_LEN;
    lsu_w_m2s.awsize  = {1'b0, size_q};
    lsu_w_m2s.awburst = `LSU_AXI_BURST_INCR;
    lsu_w_m2s.awvalid = aw_valid;
    lsu_w_m2s.wdata   = wdata_q;
    lsu_w_m2s.wstrb   = wstrb_q;
    lsu_w_m2s.wlast   = 1'b1;
    lsu_w_m2s.wvalid  = w_valid;
    lsu_w_m2s.bready  = b_ready;

    lsu_r_m2s.arid    = `LSU_AXI_ID;
    lsu_r_m2s.araddr  = addr_q;
    lsu_r_m2s.arlen   = `LSU_AXI_LEN;
    lsu_r_m2s.arsize  = {1'b0, size_q};
    lsu_r_m2s.arburst = `LSU_AXI_BURST_INCR;
    lsu_r_m2s.arvalid = ar_valid;
    lsu_r_m2s.rready  = r_ready;
  end

endmodule

//--- verilog/lsu_data_align.sv
`timescale 1ns/1ps

module lsu_data_align (
  input  lsu_pkg::access_size_t size,
  input  logic [1:0]            offset,
  input  lsu_pkg::data_t        wdata,
  input  logic                  sext,
  input  lsu_pkg::data_t        rdata_raw,
  output lsu_pkg::strb_t        wstrb,
  output lsu_pkg::data_t        wdata_lane,
  output lsu_pkg::data_t        rdata_ext
);

  lsu_pkg::strb_t base_strb;
  lsu_pkg::data_t rdata_shift;
  logic [4:0]     bit_shift;

  assign bit_shift = {offset, 3'b000};

  // Strobe pattern for the access size at lane 0.
  always_comb begin
    case (size)
      2'd0:    base_strb = lsu_pkg::strb_t'(1);
      2'd1:    base_strb = lsu_pkg::strb_t'(3);
      2'd2:    base_strb = '1;
      default: base_strb = '0;
    endcase
  end

  assign wstrb       = base_strb << offset;
  assign wdata_lane  = wdata << bit_shift;
  assign rdata_shift = rdata_raw >> bit_shift;

  // A set sext flag selects zero extension.
  always_comb begin
    case (size)
      2'd0: begin
        if (sext) begin
          rdata_ext = lsu_pkg::data_t'(rdata_shift[7:0]);
        end else begin
          rdata_ext = lsu_pkg::data_t'($signed(rdata_shift[7:0]));
        end
      end
      2'd1: begin
        if (sext) begin
          rdata_ext = lsu_pkg::data_t'(rdata_shift[15:0]);
        end else begin
          rdata_ext = lsu_pkg::data_t'($signed(rdata_shift[15:0]));
        end
      end
      default: rdata_ext = rdata_shift;
    endcase
  end

endmodule

//--- verilog/lsu_pkg.sv
`include "lsu_consts.svh"

package lsu_pkg;

  typedef logic [`LSU_DATA_W-1:0] addr_t;
  typedef logic [`LSU_DATA_W-1:0] data_t;
  typedef logic [`LSU_DATA_W/8-1:0] strb_t;

  // 0 byte, 1 half, 2 word.
  typedef logic [1:0] access_size_t;

  typedef logic [3:0] axi_id_t;
  typedef logic [7:0] axi_len_t;
  typedef logic [2:0] axi_size_t;
  typedef logic [1:0] axi_burst_t;

  typedef struct packed {
    axi_id_t    awid;
    addr_t      awaddr;
    axi_len_t   awlen;
    axi_size_t  awsize;
    axi_burst_t awburst;
    logic       awvalid;
    data_t      wdata;
    strb_t      wstrb;
    logic       wlast;
    logic       wvalid;
    logic       bready;
  } axi_w_m2s_t;

  typedef struct packed {
    logic awready;
    logic wready;
    logic bvalid;
  } axi_w_s2m_t;

  typedef struct packed {
    axi_id_t    arid;
    addr_t      araddr;
    axi_len_t   arlen;
    axi_size_t  arsize;
    axi_burst_t arburst;
    logic       arvalid;
    logic       rready;
  } axi_r_m2s_t;

  typedef struct packed {
    logic  arready;
    logic  rvalid;
    data_t rdata;
  } axi_r_s2m_t;

endpackage

//--- verilog/lsu_subsystem.sv
`timescale 1ns/1ps

module lsu_subsystem (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  exu2lsu_valid,
  output logic                  lsu2exu_ready,
  input  lsu_pkg::addr_t        lsu_addr,
  input  lsu_pkg::access_size_t lsu_size,
  input  logic                  lsu_sext,
  input  logic                  lsu_write,
  input  lsu_pkg::data_t        lsu_wdata,
  output logic                  lsu2exu_valid,
  output lsu_pkg::data_t        lsu_rdata
);

  lsu_pkg::axi_w_m2s_t w_m2s;
  lsu_pkg::axi_w_s2m_t w_s2m;
  lsu_pkg::axi_r_m2s_t r_m2s;
  lsu_pkg::axi_r_s2m_t r_s2m;

  lsu lsu_inst (
    .clock         (clock),
    .reset         (reset),
    .exu2lsu_valid (exu2lsu_valid),
    .lsu2exu_ready (lsu2exu_ready),
    .lsu_addr      (lsu_addr),
    .lsu_size      (lsu_size),
    .lsu_sext      (lsu_sext),
    .lsu_write     (lsu_write),
    .lsu_wdata     (lsu_wdata),
    .lsu2exu_valid (lsu2exu_valid),
    .lsu_rdata     (lsu_rdata),
    .lsu_w_m2s     (w_m2s),
    .lsu_w_s2m     (w_s2m),
    .lsu_r_m2s     (r_m2s),
    .lsu_r_s2m     (r_s2m)
  );

  axi_sram_slave axi_sram_slave_inst (
    .clock (clock),
    .reset (reset),
    .w_m2s (w_m2s),
    .w_s2m (w_s2m),
    .r_m2s (r_m2s),
    .r_s2m (r_s2m)
  );

endmodule
